// File: build.f
source/riscv_isa_pkg.sv
source/id_ctrl_pkg.sv
source/inst_decoder.sv
source/imm_gen.sv
source/regfile.sv
source/operand_forward.sv
source/id_stage.sv
testbench/id_checker.sv
testbench/tb_id_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decode-stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_id_stage \
	-Mdir obj_dir -o sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log

grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed" && exit 0

// File: source/id_ctrl_pkg.sv
`default_nettype none

package id_ctrl_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Execute-side selects
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [4:0] {
		alu_add,
		alu_sub,
		alu_xor,
		alu_or,
		alu_and,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_slt,   // Signed compare
		alu_sltu   // Unsigned compare
	} alu_func_e;

	typedef enum logic [1:0] {
		opa_rega,  // rs1 value
		opa_pc,
		opa_zero   // LUI adds to zero
	} opa_sel_e;

	typedef enum logic [1:0] {
		opb_regb,  // rs2 value
		opb_imm,
		opb_four   // Link address for JAL and JALR
	} opb_sel_e;

	// Everything the later stages need from decode
	typedef struct packed {
		opa_sel_e  opa_sel;
		opb_sel_e  opb_sel;
		alu_func_e alu_func;
		logic      rd_mem;         // Load
		logic      wr_mem;         // Store
		logic      cond_branch;
		logic      uncond_branch;  // JAL, JALR
		logic      reg_wr;         // Writes rd
		logic      illegal;
		logic      valid_inst;     // Counted as retired work
	} id_ctrl_t;

	// Control of a NOP, the decoder starts from this
	localparam id_ctrl_t ctrl_nop = '{
		opa_sel:       opa_rega,
		opb_sel:       opb_regb,
		alu_func:      alu_add,
		rd_mem:        1'b0,
		wr_mem:        1'b0,
		cond_branch:   1'b0,
		uncond_branch: 1'b0,
		reg_wr:        1'b0,
		illegal:       1'b0,
		valid_inst:    1'b0
	};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pipeline status
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [1:0] {
		fwd_regfile,
		fwd_id_ex,   // Nearest, result still in the ALU
		fwd_ex_mem,
		fwd_mem_wb
	} fwd_src_e;

	// One later stage as seen from decode
	typedef struct packed {
		riscv_isa_pkg::reg_idx_t dest_idx;  // Zero when nothing is written
		logic                    rd_mem;    // Data comes from memory later
	} stage_dest_t;

	// Writeback port, also the last forwarding source
	typedef struct packed {
		riscv_isa_pkg::reg_idx_t dest_idx;
		logic                    reg_wr;
		logic                    valid_inst;
		riscv_isa_pkg::word_t    data;
	} wb_port_t;

endpackage

`default_nettype wire

// File: source/id_stage.sv
`timescale 1ns/1ns
`default_nettype none

module id_stage (
	input  logic                     clk,
	input  logic                     rst_n,
	input  riscv_isa_pkg::word_t     if_id_ir,           // Held by fetch while stalled
	input  riscv_isa_pkg::word_t     if_id_pc,
	input  logic                     if_id_valid_inst,
	input  id_ctrl_pkg::stage_dest_t id_ex,
	input  id_ctrl_pkg::stage_dest_t ex_mem,
	input  riscv_isa_pkg::word_t     ex_alu_result,
	input  riscv_isa_pkg::word_t     ex_mem_alu_result,
	input  id_ctrl_pkg::wb_port_t    mem_wb,
	output id_ctrl_pkg::id_ctrl_t    ctrl,
	output riscv_isa_pkg::reg_idx_t  dest_idx,           // x0 when nothing is written
	output riscv_isa_pkg::funct3_t   funct3,             // Branch and memory flavour
	output riscv_isa_pkg::word_t     ra_value,
	output riscv_isa_pkg::word_t     rb_value,
	output riscv_isa_pkg::word_t     immediate,
	output riscv_isa_pkg::word_t     pc_add_opa,         // Base for the target adder
	output logic                     stall_en
);

	riscv_isa_pkg::reg_idx_t ra_idx;
	riscv_isa_pkg::reg_idx_t rb_idx;
	riscv_isa_pkg::reg_idx_t rd_idx;
	logic                    dest_is_rd;
	logic                    is_jalr;
	riscv_isa_pkg::word_t    rf_ra;  // Raw regfile reads
	riscv_isa_pkg::word_t    rf_rb;

	// Register fields straight from the instruction word
	assign ra_idx = if_id_ir[riscv_isa_pkg::rs1_lsb +: riscv_isa_pkg::reg_idx_w];
	assign rb_idx = if_id_ir[riscv_isa_pkg::rs2_lsb +: riscv_isa_pkg::reg_idx_w];
	assign rd_idx = if_id_ir[riscv_isa_pkg::rd_lsb +: riscv_isa_pkg::reg_idx_w];
	assign funct3 = if_id_ir[riscv_isa_pkg::funct3_lsb +: riscv_isa_pkg::funct3_w];

	assign dest_idx = dest_is_rd ? rd_idx : riscv_isa_pkg::zero_reg;

	assign is_jalr = (if_id_ir[riscv_isa_pkg::opcode_lsb +: riscv_isa_pkg::opcode_w]
		== riscv_isa_pkg::i_jalr);
	assign pc_add_opa = is_jalr ? ra_value : if_id_pc;  // JALR jumps from rs1

	inst_decoder inst_decoder_inst (
		.inst          (if_id_ir),
		.valid_inst_in (if_id_valid_inst),
		.ctrl          (ctrl),
		.dest_is_rd    (dest_is_rd)
	);

	imm_gen imm_gen_inst (
		.inst      (if_id_ir),
		.immediate (immediate)
	);

	regfile regfile_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.rda_idx  (ra_idx),
		.rdb_idx  (rb_idx),
		.rda_data (rf_ra),
		.rdb_data (rf_rb),
		.wb       (mem_wb)
	);

	operand_forward operand_forward_inst (
		.ra_idx            (ra_idx),
		.rb_idx            (rb_idx),
		.id_ex             (id_ex),
		.ex_mem            (ex_mem),
		.mem_wb            (mem_wb),
		.ex_alu_result     (ex_alu_result),
		.ex_mem_alu_result (ex_mem_alu_result),
		.rf_ra             (rf_ra),
		.rf_rb             (rf_rb),
		.ra_value          (ra_value),
		.rb_value          (rb_value),
		.stall_en          (stall_en)
	);

endmodule

`default_nettype wire

// File: source/imm_gen.sv
`timescale 1ns/1ns
`default_nettype none

module imm_gen (
	input  riscv_isa_pkg::word_t inst,
	output riscv_isa_pkg::word_t immediate
);

	riscv_isa_pkg::opcode_e opcode;
	riscv_isa_pkg::word_t   i_imm;  // ALU immediate, load offset, JALR
	riscv_isa_pkg::word_t   s_imm;  // Store offset
	riscv_isa_pkg::word_t   b_imm;  // Branch displacement
	riscv_isa_pkg::word_t   u_imm;  // Upper immediate
	riscv_isa_pkg::word_t   j_imm;  // JAL displacement

	assign opcode = riscv_isa_pkg::opcode_e'(
		inst[riscv_isa_pkg::opcode_lsb +: riscv_isa_pkg::opcode_w]);

	// Sign bit is always inst[31]
	assign i_imm = {{20{inst[31]}}, inst[31:20]};
	assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};  // Half-word units
	assign u_imm = {inst[31:12], 12'b0};
	assign j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		case (opcode)
			riscv_isa_pkg::s_type:  immediate = s_imm;
			riscv_isa_pkg::b_type:  immediate = b_imm;
			riscv_isa_pkg::j_type:  immediate = j_imm;
			riscv_isa_pkg::u_lui,
			riscv_isa_pkg::u_auipc: immediate = u_imm;
			default:                immediate = i_imm;  // I format covers the rest
		endcase
	end

endmodule

`default_nettype wire

// File: source/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
	input  riscv_isa_pkg::word_t  inst,
	input  logic                  valid_inst_in,  // Low for a bubble from fetch
	output id_ctrl_pkg::id_ctrl_t ctrl,
	output logic                  dest_is_rd      // Writeback index is rd
);

	riscv_isa_pkg::opcode_e opcode;
	riscv_isa_pkg::funct3_t funct3;
	riscv_isa_pkg::funct7_t funct7;

	// ALU function when funct7 is the base encoding
	function automatic id_ctrl_pkg::alu_func_e base_alu(input riscv_isa_pkg::funct3_t f3);
		case (f3)
			riscv_isa_pkg::funct3_add_sub: base_alu = id_ctrl_pkg::alu_add;
			riscv_isa_pkg::funct3_sll:     base_alu = id_ctrl_pkg::alu_sll;
			riscv_isa_pkg::funct3_slt:     base_alu = id_ctrl_pkg::alu_slt;
			riscv_isa_pkg::funct3_sltu:    base_alu = id_ctrl_pkg::alu_sltu;
			riscv_isa_pkg::funct3_xor:     base_alu = id_ctrl_pkg::alu_xor;
			riscv_isa_pkg::funct3_srl_sra: base_alu = id_ctrl_pkg::alu_srl;
			riscv_isa_pkg::funct3_or:      base_alu = id_ctrl_pkg::alu_or;
			riscv_isa_pkg::funct3_and:     base_alu = id_ctrl_pkg::alu_and;
			default:                       base_alu = id_ctrl_pkg::alu_add;
		endcase
	endfunction

	assign opcode = riscv_isa_pkg::opcode_e'(
		inst[riscv_isa_pkg::opcode_lsb +: riscv_isa_pkg::opcode_w]);
	assign funct3 = inst[riscv_isa_pkg::funct3_lsb +: riscv_isa_pkg::funct3_w];
	assign funct7 = inst[riscv_isa_pkg::funct7_lsb +: riscv_isa_pkg::funct7_w];

	assign dest_is_rd = ctrl.reg_wr;  // Every kept writer targets rd

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		ctrl = id_ctrl_pkg::ctrl_nop;
		case (opcode)
			riscv_isa_pkg::r_type: begin
				ctrl.reg_wr = 1'b1;
				if (funct7 == riscv_isa_pkg::funct7_base) begin
					ctrl.alu_func = base_alu(funct3);
				end else if (funct7 == riscv_isa_pkg::funct7_alt &&
					funct3 == riscv_isa_pkg::funct3_add_sub) begin
					ctrl.alu_func = id_ctrl_pkg::alu_sub;
				end else if (funct7 == riscv_isa_pkg::funct7_alt &&
					funct3 == riscv_isa_pkg::funct3_srl_sra) begin
					ctrl.alu_func = id_ctrl_pkg::alu_sra;
				end else begin
					ctrl.illegal = 1'b1;  // MUL group and junk funct7
				end
			end
			riscv_isa_pkg::i_arith: begin
				ctrl.opb_sel  = id_ctrl_pkg::opb_imm;
				ctrl.reg_wr   = 1'b1;
				ctrl.alu_func = base_alu(funct3);
				// Shift amounts leave funct7 in the upper immediate bits
				if (funct3 == riscv_isa_pkg::funct3_sll) begin
					ctrl.illegal = (funct7 != riscv_isa_pkg::funct7_base);
				end else if (funct3 == riscv_isa_pkg::funct3_srl_sra) begin
					if (funct7 == riscv_isa_pkg::funct7_alt)
						ctrl.alu_func = id_ctrl_pkg::alu_sra;
					else
						ctrl.illegal = (funct7 != riscv_isa_pkg::funct7_base);
				end
			end
			riscv_isa_pkg::i_load: begin
				ctrl.opb_sel = id_ctrl_pkg::opb_imm;  // Address = rs1 + imm
				ctrl.rd_mem  = 1'b1;
				ctrl.reg_wr  = 1'b1;
				ctrl.illegal = (funct3 != riscv_isa_pkg::funct3_lw);
			end
			riscv_isa_pkg::s_type: begin
				ctrl.opb_sel = id_ctrl_pkg::opb_imm;
				if (funct3 == riscv_isa_pkg::funct3_sw)
					ctrl.wr_mem = 1'b1;
				else
					ctrl.illegal = 1'b1;
			end
			riscv_isa_pkg::b_type: begin
				ctrl.opa_sel     = id_ctrl_pkg::opa_pc;  // Target = pc + imm
				ctrl.opb_sel     = id_ctrl_pkg::opb_imm;
				ctrl.cond_branch = 1'b1;
				ctrl.illegal     = (funct3[2:1] == 2'b01);  // No branch on 010/011
			end
			riscv_isa_pkg::j_type: begin
				ctrl.opa_sel       = id_ctrl_pkg::opa_pc;
				ctrl.opb_sel       = id_ctrl_pkg::opb_four;  // rd = pc + 4
				ctrl.uncond_branch = 1'b1;
				ctrl.reg_wr        = 1'b1;
			end
			riscv_isa_pkg::i_jalr: begin
				ctrl.opa_sel       = id_ctrl_pkg::opa_pc;
				ctrl.opb_sel       = id_ctrl_pkg::opb_four;
				ctrl.uncond_branch = 1'b1;
				ctrl.reg_wr        = 1'b1;
				ctrl.illegal       = (funct3 != riscv_isa_pkg::funct3_jalr);
			end
			riscv_isa_pkg::u_lui: begin
				ctrl.opa_sel = id_ctrl_pkg::opa_zero;
				ctrl.opb_sel = id_ctrl_pkg::opb_imm;
				ctrl.reg_wr  = 1'b1;
			end
			riscv_isa_pkg::u_auipc: begin
				ctrl.opa_sel = id_ctrl_pkg::opa_pc;
				ctrl.opb_sel = id_ctrl_pkg::opb_imm;
				ctrl.reg_wr  = 1'b1;
			end
			riscv_isa_pkg::i_system: begin
				// EBREAK has rd, rs1 and funct3 all zero
				ctrl.illegal = (inst[riscv_isa_pkg::imm12_lsb +: riscv_isa_pkg::imm12_w]
					!= riscv_isa_pkg::ebreak_imm) || (funct3 != '0) ||
					(inst[riscv_isa_pkg::rs1_lsb +: riscv_isa_pkg::reg_idx_w] != '0) ||
					(inst[riscv_isa_pkg::rd_lsb +: riscv_isa_pkg::reg_idx_w] != '0);
			end
			default: ctrl.illegal = 1'b1;  // Unknown opcode
		endcase
		ctrl.valid_inst = valid_inst_in & ~ctrl.illegal;

		// Memory port takes one direction per instruction
		assert (!(ctrl.rd_mem && ctrl.wr_mem))
			else $error("inst_decoder: load and store flags both set");
	end

endmodule

`default_nettype wire

// File: source/operand_forward.sv
`timescale 1ns/1ns
`default_nettype none

module operand_forward (
	input  riscv_isa_pkg::reg_idx_t  ra_idx,
	input  riscv_isa_pkg::reg_idx_t  rb_idx,
	input  id_ctrl_pkg::stage_dest_t id_ex,
	input  id_ctrl_pkg::stage_dest_t ex_mem,
	input  id_ctrl_pkg::wb_port_t    mem_wb,
	input  riscv_isa_pkg::word_t     ex_alu_result,      // id_ex result
	input  riscv_isa_pkg::word_t     ex_mem_alu_result,
	input  riscv_isa_pkg::word_t     rf_ra,
	input  riscv_isa_pkg::word_t     rf_rb,
	output riscv_isa_pkg::word_t     ra_value,
	output riscv_isa_pkg::word_t     rb_value,
	output logic                     stall_en
);

	logic [2:0]            ra_hit;   // {mem_wb, ex_mem, id_ex}
	logic [2:0]            rb_hit;
	logic [2:0]            fwd_ok;   // Stage can hand over data now
	id_ctrl_pkg::fwd_src_e ra_src;
	id_ctrl_pkg::fwd_src_e rb_src;

	function automatic logic dest_hit(input riscv_isa_pkg::reg_idx_t idx,
		input riscv_isa_pkg::reg_idx_t dest);
		dest_hit = (dest != riscv_isa_pkg::zero_reg) && (idx == dest);  // x0 never matches
	endfunction

	// Nearest usable stage wins
	function automatic id_ctrl_pkg::fwd_src_e pick_src(input logic [2:0] usable);
		if (usable[0])
			pick_src = id_ctrl_pkg::fwd_id_ex;
		else if (usable[1])
			pick_src = id_ctrl_pkg::fwd_ex_mem;
		else if (usable[2])
			pick_src = id_ctrl_pkg::fwd_mem_wb;
		else
			pick_src = id_ctrl_pkg::fwd_regfile;
	endfunction

	function automatic riscv_isa_pkg::word_t src_value(input id_ctrl_pkg::fwd_src_e src,
		input riscv_isa_pkg::word_t rf_value);
		case (src)
			id_ctrl_pkg::fwd_id_ex:  src_value = ex_alu_result;
			id_ctrl_pkg::fwd_ex_mem: src_value = ex_mem_alu_result;
			id_ctrl_pkg::fwd_mem_wb: src_value = mem_wb.data;
			default:                 src_value = rf_value;
		endcase
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Matches, computed once each
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign ra_hit = {dest_hit(ra_idx, mem_wb.dest_idx), dest_hit(ra_idx, ex_mem.dest_idx),
		dest_hit(ra_idx, id_ex.dest_idx)};
	assign rb_hit = {dest_hit(rb_idx, mem_wb.dest_idx), dest_hit(rb_idx, ex_mem.dest_idx),
		dest_hit(rb_idx, id_ex.dest_idx)};

	always_comb begin
		fwd_ok = {1'b1, ~ex_mem.rd_mem, ~id_ex.rd_mem};  // Load data not back yet
		ra_src = pick_src(ra_hit & fwd_ok);
		rb_src = pick_src(rb_hit & fwd_ok);

		// A load in execute must never feed decode
		assert (!id_ex.rd_mem ||
			(ra_src != id_ctrl_pkg::fwd_id_ex && rb_src != id_ctrl_pkg::fwd_id_ex))
			else $error("operand_forward: id_ex load chosen as forwarding source");
	end

	assign ra_value = src_value(ra_src, rf_ra);
	assign rb_value = src_value(rb_src, rf_rb);

	// Hazard left unresolved by forwarding, so hold fetch
	assign stall_en = (|ra_hit && ra_src == id_ctrl_pkg::fwd_regfile) ||
		(|rb_hit && rb_src == id_ctrl_pkg::fwd_regfile);

endmodule

`default_nettype wire

// File: source/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile (
	input  logic                    clk,
	input  logic                    rst_n,
	input  riscv_isa_pkg::reg_idx_t rda_idx,
	input  riscv_isa_pkg::reg_idx_t rdb_idx,
	output riscv_isa_pkg::word_t    rda_data,
	output riscv_isa_pkg::word_t    rdb_data,
	input  id_ctrl_pkg::wb_port_t   wb        // Writeback from mem_wb
);

	riscv_isa_pkg::word_t regs [riscv_isa_pkg::reg_count];
	logic                 wr_en;

	// Only retired writers, and never x0
	assign wr_en = wb.valid_inst && wb.reg_wr && (wb.dest_idx != riscv_isa_pkg::zero_reg);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < riscv_isa_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb.dest_idx] <= wb.data;  // Visible to reads next cycle
		end
	end

	// Asynchronous reads, x0 forced to zero
	assign rda_data = (rda_idx == riscv_isa_pkg::zero_reg) ? '0 : regs[rda_idx];
	assign rdb_data = (rdb_idx == riscv_isa_pkg::zero_reg) ? '0 : regs[rdb_idx];

	// x0 storage keeps its reset value for the whole run
	assert property (@(posedge clk) disable iff (!rst_n)
		regs[riscv_isa_pkg::zero_reg] == '0)
		else $error("regfile: x0 storage was written");

endmodule

`default_nettype wire

// File: source/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Widths and basic types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int xlen      = 32;  // Data path width
	localparam int reg_idx_w = 5;
	localparam int reg_count = 1 << reg_idx_w;  // x0..x31
	localparam int opcode_w  = 7;
	localparam int funct3_w  = 3;
	localparam int funct7_w  = 7;
	localparam int imm12_w   = 12;  // I-type immediate field

	typedef logic [xlen-1:0]      word_t;
	typedef logic [reg_idx_w-1:0] reg_idx_t;
	typedef logic [funct3_w-1:0]  funct3_t;
	typedef logic [funct7_w-1:0]  funct7_t;

	localparam reg_idx_t zero_reg = '0;  // Hardwired zero

	// Bit positions of the instruction fields
	localparam int opcode_lsb = 0;
	localparam int rd_lsb     = 7;
	localparam int funct3_lsb = 12;
	localparam int rs1_lsb    = 15;
	localparam int rs2_lsb    = 20;
	localparam int imm12_lsb  = 20;  // Shares bits with rs2
	localparam int funct7_lsb = 25;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Major opcodes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [opcode_w-1:0] {
		r_type   = 7'b0110011,  // Register-register ALU
		i_arith  = 7'b0010011,  // Register-immediate ALU
		i_load   = 7'b0000011,
		s_type   = 7'b0100011,  // Stores
		b_type   = 7'b1100011,  // Conditional branches
		j_type   = 7'b1101111,  // JAL
		i_jalr   = 7'b1100111,
		u_lui    = 7'b0110111,
		u_auipc  = 7'b0010111,
		i_system = 7'b1110011   // Only EBREAK is kept
	} opcode_e;

	// funct3 of the ALU group, shared by R and I forms
	localparam funct3_t funct3_add_sub = 3'd0;
	localparam funct3_t funct3_sll     = 3'd1;
	localparam funct3_t funct3_slt     = 3'd2;
	localparam funct3_t funct3_sltu    = 3'd3;
	localparam funct3_t funct3_xor     = 3'd4;
	localparam funct3_t funct3_srl_sra = 3'd5;
	localparam funct3_t funct3_or      = 3'd6;
	localparam funct3_t funct3_and     = 3'd7;

	localparam funct3_t funct3_lw   = 3'd2;  // Word load only
	localparam funct3_t funct3_sw   = 3'd2;  // Word store only
	localparam funct3_t funct3_jalr = 3'd0;

	localparam funct7_t funct7_base = 7'h00;
	localparam funct7_t funct7_alt  = 7'h20;  // SUB and SRA

	localparam logic [imm12_w-1:0] ebreak_imm = 12'h001;  // ECALL has 0 here

endpackage

`default_nettype wire

// File: testbench/id_checker.sv
`timescale 1ns/1ns
`default_nettype none

module id_checker (
	input  logic                    clk,
	input  logic                    check_en,  // Row inputs were applied last cycle
	input  int                      row_id,
	input  logic                    done,
	input  id_ctrl_pkg::id_ctrl_t   ctrl,
	input  riscv_isa_pkg::reg_idx_t dest_idx,
	input  riscv_isa_pkg::funct3_t  funct3,
	input  riscv_isa_pkg::word_t    ra_value,
	input  riscv_isa_pkg::word_t    rb_value,
	input  riscv_isa_pkg::word_t    immediate,
	input  riscv_isa_pkg::word_t    pc_add_opa,
	input  logic                    stall_en,
	input  id_ctrl_pkg::id_ctrl_t   exp_ctrl,
	input  riscv_isa_pkg::reg_idx_t exp_dest,
	input  riscv_isa_pkg::funct3_t  exp_funct3,
	input  riscv_isa_pkg::word_t    exp_ra,
	input  riscv_isa_pkg::word_t    exp_rb,
	input  riscv_isa_pkg::word_t    exp_imm,
	input  riscv_isa_pkg::word_t    exp_pc_opa,
	input  logic                    exp_stall,
	output int                      err_count,
	output int                      pass_count
);

	logic row_bad;         // Any field of this row differed
	logic reported = 1'b0;

	initial begin
		err_count = 0;
		pass_count = 0;
	end

	// One line per differing field
	task automatic compare_field(input string what, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			row_bad = 1'b1;
			$display("CHECK FAILED at %0t ns: row %0d %s is %h, expected %h",
				$time, row_id, what, got, want);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Compare on the edge after drive
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(posedge clk) begin
		if (check_en) begin
			row_bad = 1'b0;
			compare_field("ctrl", 32'(ctrl), 32'(exp_ctrl));  // Whole decode struct
			compare_field("dest_idx", 32'(dest_idx), 32'(exp_dest));
			compare_field("funct3", 32'(funct3), 32'(exp_funct3));
			compare_field("immediate", immediate, exp_imm);
			compare_field("ra_value", ra_value, exp_ra);
			compare_field("rb_value", rb_value, exp_rb);
			compare_field("pc_add_opa", pc_add_opa, exp_pc_opa);
			compare_field("stall_en", 32'(stall_en), 32'(exp_stall));
			if (row_bad) begin
				err_count = err_count + 1;
				$display("Row %0d failed", row_id);
			end else begin
				pass_count = pass_count + 1;
				$display("Row %0d passed", row_id);
			end
		end
		if (done && !reported) begin
			reported = 1'b1;
			$display("Rows checked %0d, passed %0d, failed %0d",
				err_count + pass_count, pass_count, err_count);
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_id_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage;

	localparam int num_rows   = 32;
	localparam int reset_cyc  = 8;
	localparam int preload    = 32;  // Write attempts to x0..x31
	localparam int max_cycles = reset_cyc + preload + num_rows + 20;

	// Fixed data of the forwarding sources
	localparam riscv_isa_pkg::word_t ex_res  = 32'hE0E0_0001;
	localparam riscv_isa_pkg::word_t exm_res = 32'hE3E3_0002;
	localparam riscv_isa_pkg::word_t wb_res  = 32'hB0B0_0003;

	localparam id_ctrl_pkg::opa_sel_e a_reg  = id_ctrl_pkg::opa_rega;
	localparam id_ctrl_pkg::opa_sel_e a_pc   = id_ctrl_pkg::opa_pc;
	localparam id_ctrl_pkg::opa_sel_e a_zero = id_ctrl_pkg::opa_zero;
	localparam id_ctrl_pkg::opb_sel_e b_reg  = id_ctrl_pkg::opb_regb;
	localparam id_ctrl_pkg::opb_sel_e b_imm  = id_ctrl_pkg::opb_imm;
	localparam id_ctrl_pkg::opb_sel_e b_four = id_ctrl_pkg::opb_four;

	// One stimulus row with its expected columns
	typedef struct packed {
		riscv_isa_pkg::word_t     inst;
		logic                     vin;    // Fetch valid
		id_ctrl_pkg::stage_dest_t ie;     // id_ex status
		id_ctrl_pkg::stage_dest_t em;     // ex_mem status
		riscv_isa_pkg::reg_idx_t  wbd;    // mem_wb dest, never written
		id_ctrl_pkg::id_ctrl_t    ctrl;
		riscv_isa_pkg::reg_idx_t  dest;
		riscv_isa_pkg::word_t     imm;
		logic [1:0]               sa;     // 0 regfile, 1 id_ex, 2 ex_mem, 3 mem_wb
		logic [1:0]               sb;
		logic                     stall;
	} row_t;

	logic                     clk = 1'b0;
	logic                     rst_n;
	riscv_isa_pkg::word_t     if_id_ir;
	riscv_isa_pkg::word_t     if_id_pc;
	logic                     if_id_valid_inst;
	id_ctrl_pkg::stage_dest_t id_ex;
	id_ctrl_pkg::stage_dest_t ex_mem;
	riscv_isa_pkg::word_t     ex_alu_result;
	riscv_isa_pkg::word_t     ex_mem_alu_result;
	id_ctrl_pkg::wb_port_t    mem_wb;
	id_ctrl_pkg::id_ctrl_t    ctrl;
	riscv_isa_pkg::reg_idx_t  dest_idx;
	riscv_isa_pkg::funct3_t   funct3;
	riscv_isa_pkg::word_t     ra_value;
	riscv_isa_pkg::word_t     rb_value;
	riscv_isa_pkg::word_t     immediate;
	riscv_isa_pkg::word_t     pc_add_opa;
	logic                     stall_en;

	// Expected values travel to the checker with the inputs
	logic                    check_en;
	int                      row_id;
	id_ctrl_pkg::id_ctrl_t   exp_ctrl;
	riscv_isa_pkg::reg_idx_t exp_dest;
	riscv_isa_pkg::funct3_t  exp_funct3;
	riscv_isa_pkg::word_t    exp_ra;
	riscv_isa_pkg::word_t    exp_rb;
	riscv_isa_pkg::word_t    exp_imm;
	riscv_isa_pkg::word_t    exp_pc_opa;
	logic                    exp_stall;
	logic                    done;
	int                      err_count;
	int                      pass_count;

	row_t                 rows [num_rows];
	int                   row_cnt = 0;
	riscv_isa_pkg::word_t shadow [32];  // Model of the register file
	int                   cycles = 0;

	always #4 clk = ~clk;  // 8 ns period

	id_stage id_stage_inst (
		.clk (clk), .rst_n (rst_n),
		.if_id_ir (if_id_ir), .if_id_pc (if_id_pc), .if_id_valid_inst (if_id_valid_inst),
		.id_ex (id_ex), .ex_mem (ex_mem),
		.ex_alu_result (ex_alu_result), .ex_mem_alu_result (ex_mem_alu_result),
		.mem_wb (mem_wb), .ctrl (ctrl), .dest_idx (dest_idx), .funct3 (funct3),
		.ra_value (ra_value), .rb_value (rb_value), .immediate (immediate),
		.pc_add_opa (pc_add_opa), .stall_en (stall_en)
	);

	id_checker id_checker_inst (
		.clk (clk), .check_en (check_en), .row_id (row_id), .done (done),
		.ctrl (ctrl), .dest_idx (dest_idx), .funct3 (funct3),
		.ra_value (ra_value), .rb_value (rb_value), .immediate (immediate),
		.pc_add_opa (pc_add_opa), .stall_en (stall_en),
		.exp_ctrl (exp_ctrl), .exp_dest (exp_dest), .exp_funct3 (exp_funct3),
		.exp_ra (exp_ra), .exp_rb (exp_rb), .exp_imm (exp_imm),
		.exp_pc_opa (exp_pc_opa), .exp_stall (exp_stall),
		.err_count (err_count), .pass_count (pass_count)
	);

	function automatic riscv_isa_pkg::word_t xorshift(input riscv_isa_pkg::word_t x);
		riscv_isa_pkg::word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// flags are {rd_mem, wr_mem, cond_branch, uncond_branch, reg_wr}
	function automatic id_ctrl_pkg::id_ctrl_t mk_ctrl(input id_ctrl_pkg::opa_sel_e opa,
		input id_ctrl_pkg::opb_sel_e opb, input id_ctrl_pkg::alu_func_e alu,
		input logic [4:0] flags, input logic ill, input logic vin);
		id_ctrl_pkg::id_ctrl_t c;
		c.opa_sel = opa;
		c.opb_sel = opb;
		c.alu_func = alu;
		{c.rd_mem, c.wr_mem, c.cond_branch, c.uncond_branch, c.reg_wr} = flags;
		c.illegal = ill;
		c.valid_inst = vin & ~ill;  // Illegal words never retire
		return c;
	endfunction

	// Operand value from the source named in the table
	function automatic riscv_isa_pkg::word_t expected_operand(input logic [1:0] src,
		input riscv_isa_pkg::reg_idx_t idx);
		case (src)
			2'd1:    return ex_res;
			2'd2:    return exm_res;
			2'd3:    return wb_res;
			default: return (idx == 5'd0) ? 32'd0 : shadow[idx];
		endcase
	endfunction

	task automatic add_row(input riscv_isa_pkg::word_t inst, input logic vin,
		input id_ctrl_pkg::stage_dest_t ie, input id_ctrl_pkg::stage_dest_t em,
		input riscv_isa_pkg::reg_idx_t wbd, input id_ctrl_pkg::id_ctrl_t c,
		input riscv_isa_pkg::reg_idx_t dest, input riscv_isa_pkg::word_t imm,
		input logic [1:0] sa, input logic [1:0] sb, input logic stall);
		rows[row_cnt] = '{inst, vin, ie, em, wbd, c, dest, imm, sa, sb, stall};
		row_cnt++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus table
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic fill_table();
		id_ctrl_pkg::id_ctrl_t c_add;
		c_add = mk_ctrl(a_reg, b_reg, id_ctrl_pkg::alu_add, 5'b00001, 1'b0, 1'b1);
		add_row(32'h002081B3, 1, 6'd0, 6'd0, 5'd0, c_add, 5'd3, 32'h2, 0, 0, 0);  // ADD
		add_row(32'h40628233, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_reg, b_reg,
			id_ctrl_pkg::alu_sub, 5'b00001, 0, 1), 5'd4, 32'h406, 0, 0, 0);
		add_row(32'h409453B3, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_reg, b_reg,
			id_ctrl_pkg::alu_sra, 5'b00001, 0, 1), 5'd7, 32'h409, 0, 0, 0);
		add_row(32'h023100B3, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_reg, b_reg,
			id_ctrl_pkg::alu_add, 5'b00001, 1, 1), 5'd1, 32'h23, 0, 0, 0);  // MUL dropped
		add_row(32'hFFF58513, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_reg, b_imm,
			id_ctrl_pkg::alu_add, 5'b00001, 0, 1), 5'd10, 32'hFFFFFFFF, 0, 0, 0);
		add_row(32'h4036D613, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_reg, b_imm,
			id_ctrl_pkg::alu_sra, 5'b00001, 0, 1), 5'd12, 32'h403, 0, 0, 0);  // SRAI
		add_row(32'h40109113, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_reg, b_imm,
			id_ctrl_pkg::alu_sll, 5'b00001, 1, 1), 5'd2, 32'h401, 0, 0, 0);
		add_row(32'h0057B713, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_reg, b_imm,
			id_ctrl_pkg::alu_sltu, 5'b00001, 0, 1), 5'd14, 32'h5, 0, 0, 0);
		add_row(32'h0088A803, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_reg, b_imm,
			id_ctrl_pkg::alu_add, 5'b10001, 0, 1), 5'd16, 32'h8, 0, 0, 0);  // LW
		add_row(32'h00408103, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_reg, b_imm,
			id_ctrl_pkg::alu_add, 5'b10001, 1, 1), 5'd2, 32'h4, 0, 0, 0);  // LB
		add_row(32'hFF29AE23, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_reg, b_imm,
			id_ctrl_pkg::alu_add, 5'b01000, 0, 1), 5'd0, 32'hFFFFFFFC, 0, 0, 0);
		add_row(32'h00209023, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_reg, b_imm,
			id_ctrl_pkg::alu_add, 5'b00000, 1, 1), 5'd0, 32'h0, 0, 0, 0);  // SH
		add_row(32'h015A0863, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_pc, b_imm,
			id_ctrl_pkg::alu_add, 5'b00100, 0, 1), 5'd0, 32'h10, 0, 0, 0);
		add_row(32'hFE209CE3, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_pc, b_imm,
			id_ctrl_pkg::alu_add, 5'b00100, 0, 1), 5'd0, 32'hFFFFFFF8, 0, 0, 0);
		add_row(32'h0020A463, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_pc, b_imm,
			id_ctrl_pkg::alu_add, 5'b00100, 1, 1), 5'd0, 32'h8, 0, 0, 0);
		add_row(32'h001000EF, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_pc, b_four,
			id_ctrl_pkg::alu_add, 5'b00011, 0, 1), 5'd1, 32'h800, 0, 0, 0);  // JAL
		add_row(32'h00C302E7, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_pc, b_four,
			id_ctrl_pkg::alu_add, 5'b00011, 0, 1), 5'd5, 32'hC, 0, 0, 0);
		add_row(32'h00C302E7, 1, {5'd6, 1'b0}, 6'd0, 5'd0, mk_ctrl(a_pc, b_four,
			id_ctrl_pkg::alu_add, 5'b00011, 0, 1), 5'd5, 32'hC, 1, 0, 0);  // Base forwarded
		add_row(32'h12345437, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_zero, b_imm,
			id_ctrl_pkg::alu_add, 5'b00001, 0, 1), 5'd8, 32'h12345000, 0, 0, 0);
		add_row(32'hFFFFF497, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_pc, b_imm,
			id_ctrl_pkg::alu_add, 5'b00001, 0, 1), 5'd9, 32'hFFFFF000, 0, 0, 0);
		add_row(32'h00100073, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_reg, b_reg,
			id_ctrl_pkg::alu_add, 5'b00000, 0, 1), 5'd0, 32'h1, 0, 0, 0);  // EBREAK
		add_row(32'h00000073, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_reg, b_reg,
			id_ctrl_pkg::alu_add, 5'b00000, 1, 1), 5'd0, 32'h0, 0, 0, 0);
		add_row(32'h00101073, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_reg, b_reg,
			id_ctrl_pkg::alu_add, 5'b00000, 1, 1), 5'd0, 32'h1, 0, 0, 0);  // CSRRW
		add_row(32'hFFFFFFFF, 1, 6'd0, 6'd0, 5'd0, mk_ctrl(a_reg, b_reg,
			id_ctrl_pkg::alu_add, 5'b00000, 1, 1), 5'd0, 32'hFFFFFFFF, 0, 0, 0);
		add_row(32'h002081B3, 0, 6'd0, 6'd0, 5'd0, mk_ctrl(a_reg, b_reg,
			id_ctrl_pkg::alu_add, 5'b00001, 0, 0), 5'd3, 32'h2, 0, 0, 0);  // Bubble
		// Forwarding and stall rows use ADD x3, x1, x2
		add_row(32'h002081B3, 1, {5'd1, 1'b0}, {5'd1, 1'b0}, 5'd1, c_add, 5'd3, 32'h2, 1, 0, 0);
		add_row(32'h002081B3, 1, {5'd1, 1'b1}, {5'd1, 1'b0}, 5'd0, c_add, 5'd3, 32'h2, 2, 0, 0);
		add_row(32'h002081B3, 1, {5'd2, 1'b1}, 6'd0, 5'd0, c_add, 5'd3, 32'h2, 0, 0, 1);
		add_row(32'h002081B3, 1, {5'd2, 1'b0}, {5'd1, 1'b1}, 5'd1, c_add, 5'd3, 32'h2, 3, 1, 0);
		add_row(32'h002081B3, 1, 6'd0, {5'd2, 1'b1}, 5'd0, c_add, 5'd3, 32'h2, 0, 0, 1);
		add_row(32'h002081B3, 1, {5'd0, 1'b1}, 6'd0, 5'd2, c_add, 5'd3, 32'h2, 0, 3, 0);
		add_row(32'h000001B3, 1, 6'd0, 6'd0, 5'd0, c_add, 5'd3, 32'h0, 0, 0, 0);  // x0 reads
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", max_cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial begin
		row_t                 r;
		riscv_isa_pkg::word_t v;
		riscv_isa_pkg::word_t ra_e;
		riscv_isa_pkg::word_t rb_e;
		riscv_isa_pkg::word_t pc_val;
		rst_n = 1'b0;
		if_id_ir = 32'h0000_0013;  // NOP
		if_id_pc = '0;
		if_id_valid_inst = 1'b0;
		id_ex = '0;
		ex_mem = '0;
		ex_alu_result = ex_res;
		ex_mem_alu_result = exm_res;
		mem_wb = '0;
		check_en = 1'b0;
		row_id = 0;
		{exp_ctrl, exp_dest, exp_funct3, exp_ra, exp_rb} = '0;
		{exp_imm, exp_pc_opa, exp_stall, done} = '0;
		fill_table();
		repeat (reset_cyc) @(posedge clk);
		rst_n <= 1'b1;

		// Preload x1..x31 through the writeback port, the x0 write must be dropped
		v = 32'd94;
		for (int i = 0; i < 32; i++) begin
			@(posedge clk);
			v = xorshift(v);
			shadow[i] = (i == 0) ? 32'd0 : v;  // x0 stays zero
			mem_wb <= {5'(i), 1'b1, 1'b1, v};
		end

		for (int i = 0; i < row_cnt; i++) begin
			@(posedge clk);
			r = rows[i];
			pc_val = 32'h1000 + 32'(i * 4);
			ra_e = expected_operand(r.sa, r.inst[19:15]);
			rb_e = expected_operand(r.sb, r.inst[24:20]);
			if_id_ir <= r.inst;
			if_id_pc <= pc_val;
			if_id_valid_inst <= r.vin;
			id_ex <= r.ie;
			ex_mem <= r.em;
			mem_wb <= {r.wbd, 1'b0, 1'b0, wb_res};  // Forwards only and never writes
			check_en <= 1'b1;
			row_id <= i;
			exp_ctrl <= r.ctrl;
			exp_dest <= r.dest;
			exp_funct3 <= r.inst[14:12];
			exp_ra <= ra_e;
			exp_rb <= rb_e;
			exp_imm <= r.imm;
			exp_pc_opa <= (r.inst[6:0] == 7'b1100111) ? ra_e : pc_val;  // JALR uses rs1
			exp_stall <= r.stall;
		end
		@(posedge clk);
		check_en <= 1'b0;
		done <= 1'b1;
		repeat (2) @(posedge clk);
		if (err_count == 0 && pass_count == num_rows)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
